//--- Bender.yml
package:
  name: spi_acq

sources:
  - src/spi_acq_pkg.sv
  - src/acq_ctrl_regs.sv
  - src/intan_cmd_seq.sv
  - src/spi_master_engine.sv
  - src/mua_packer.sv
  - src/host_stream_fifo.sv
  - src/spi_acq_top.sv
  - target: test
    files:
      - tests/spi_acq_tb.sv

//--- src/acq_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module acq_ctrl_regs #(
  parameter int MAX_CH = 32
) (
  input  logic                              bus_clk,
  input  logic                              reset,
  input  logic                              reg_wren,
  input  logic                              reg_rden,
  input  logic [spi_acq_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [spi_acq_pkg::REG_DATA_W-1:0] reg_wdata,
  input  logic                              running,
  input  logic [15:0]                       frame_count,
  input  logic                              overflow_pulse,
  output logic [spi_acq_pkg::REG_DATA_W-1:0] reg_rdata,
  output logic                              run,
  output logic [6:0]                        num_ch,
  output logic                              filter_en
);

  import spi_acq_pkg::*;

  logic                  overflow;
  logic [6:0]            num_ch_clamped;
  logic [REG_DATA_W-1:0] read_mux;

  // Keep channel count inside 1..MAX_CH
  always_comb begin
    if (reg_wdata == '0) begin
      num_ch_clamped = 7'd1;
    end else if (reg_wdata > REG_DATA_W'(MAX_CH)) begin
      num_ch_clamped = 7'(MAX_CH);
    end else begin
      num_ch_clamped = reg_wdata[6:0];
    end
  end

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      run       <= 1'b0;
      num_ch    <= 7'(MAX_CH);
      filter_en <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      if (overflow_pulse) begin
        overflow <= 1'b1;
      end
      if (reg_wren) begin
        case (reg_addr)
          REG_RUN: begin
            run      <= reg_wdata[0];
            overflow <= 1'b0;
          end
          REG_NUM_CH:    num_ch    <= num_ch_clamped;
          REG_FILTER_EN: filter_en <= reg_wdata[0];
          default: ;
        endcase
      end
    end
  end

  // Read mux over settings and status
  always_comb begin
    case (reg_addr)
      REG_RUN:       read_mux = REG_DATA_W'(run);
      REG_NUM_CH:    read_mux = REG_DATA_W'(num_ch);
      REG_FILTER_EN: read_mux = REG_DATA_W'(filter_en);
      REG_STATUS:    read_mux = REG_DATA_W'({overflow, running});
      REG_FRAME_CNT: read_mux = frame_count;
      default:       read_mux = '0;
    endcase
  end

  // Read data held until the next read strobe
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      reg_rdata <= '0;
    end else if (reg_rden) begin
      reg_rdata <= read_mux;
    end
  end

endmodule

`default_nettype wire

//--- src/host_stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module host_stream_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                          bus_clk,
  input  logic                          reset,
  input  logic                          word_valid,
  input  logic [spi_acq_pkg::HOST_W-1:0] word_data,
  input  logic                          fifo_rden,
  output logic [spi_acq_pkg::HOST_W-1:0] fifo_data,
  output logic                          fifo_empty,
  output logic                          overflow_pulse
);

  import spi_acq_pkg::*;

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  logic [HOST_W-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          wr_en;
  logic          rd_en;

  assign full       = (count == CW'(FIFO_DEPTH));
  assign fifo_empty = (count == '0);
  assign wr_en      = word_valid && !full;
  assign rd_en      = fifo_rden && !fifo_empty;

  // Head of queue shows without a read
  assign fifo_data = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      overflow_pulse <= 1'b0;
    end else begin
      overflow_pulse <= word_valid && full;
      if (wr_en) begin
        wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: ;
      endcase
    end
  end

  always_ff @(posedge bus_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= word_data;
    end
  end

  a_no_pop_empty: assert property (@(posedge bus_clk) disable iff (reset)
    fifo_rden |-> !fifo_empty)
    else $error("host popped the stream FIFO while it was empty");

endmodule

`default_nettype wire

//--- src/intan_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module intan_cmd_seq #(
  parameter int MAX_CH = 32
) (
  input  logic                        bus_clk,
  input  logic                        reset,
  input  logic                        run,
  input  logic [6:0]                  num_ch,
  input  logic                        cmd_ready,
  output logic                        cmd_valid,
  output spi_acq_pkg::intan_cmd_u     cmd_word,
  output logic                        cmd_is_read,
  output logic [spi_acq_pkg::CH_W-1:0] cmd_channel,
  output logic                        running,
  output logic [15:0]                 frame_count
);

  import spi_acq_pkg::*;

  // Slots 0..n-1 convert, slot n and n+1 read the chip ID
  logic [6:0] n_q;
  logic [6:0] slot;
  logic       accept;
  logic       last_slot;

  assign accept    = cmd_valid && cmd_ready;
  assign last_slot = (slot == n_q + 7'd1);
  assign cmd_valid = running;

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      running     <= 1'b0;
      n_q         <= 7'd1;
      slot        <= '0;
      frame_count <= '0;
    end else if (!running) begin
      if (run) begin
        running <= 1'b1;
        n_q     <= (num_ch > 7'(MAX_CH)) ? 7'(MAX_CH) : num_ch;
        slot    <= '0;
      end
    end else if (accept) begin
      if (last_slot) begin
        frame_count <= frame_count + 16'd1;
        slot        <= '0;
        // Stop only at a frame boundary
        if (run) begin
          n_q <= (num_ch > 7'(MAX_CH)) ? 7'(MAX_CH) : num_ch;
        end else begin
          running <= 1'b0;
        end
      end else begin
        slot <= slot + 7'd1;
      end
    end
  end

  // Word follows slot, which only moves on acceptance
  always_comb begin
    cmd_word = '0;
    if (slot < n_q) begin
      cmd_word.conv.opcode  = OP_CONVERT;
      cmd_word.conv.channel = slot[5:0];
      cmd_word.conv.zero    = '0;
    end else begin
      cmd_word.regv.opcode   = OP_READ;
      cmd_word.regv.reg_addr = (slot == n_q) ? CHIP_ID_REG0 : CHIP_ID_REG1;
      cmd_word.regv.data     = '0;
    end
  end

  assign cmd_is_read = (slot >= n_q);
  assign cmd_channel = CH_W'(slot);

  a_cmd_hold: assert property (@(posedge bus_clk) disable iff (reset)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_word))
    else $error("command word changed before it was accepted");

endmodule

`default_nettype wire

//--- src/mua_packer.sv
`timescale 1ns/1ps
`default_nettype none

module mua_packer #(
  parameter int MAX_CH = 32
) (
  input  logic                          bus_clk,
  input  logic                          reset,
  input  logic                          running,
  input  logic                          filter_en,
  input  logic                          cmd_valid,
  input  logic                          cmd_ready,
  input  logic                          cmd_is_read,
  input  logic [spi_acq_pkg::CH_W-1:0]   cmd_channel,
  input  logic                          rx_valid,
  input  logic [spi_acq_pkg::CMD_W-1:0]  rx_word,
  output logic                          word_valid,
  output logic [spi_acq_pkg::HOST_W-1:0] word_data
);

  import spi_acq_pkg::*;

  localparam int IDX_W = (MAX_CH > 1) ? $clog2(MAX_CH) : 1;
  localparam int VAL_W = CMD_W + 1;

  logic              accept;
  logic              running_q;
  logic              start;
  logic              cur_read;
  logic [CH_W-1:0]   cur_ch;
  logic [1:0]        hist_read;
  logic [CH_W-1:0]   hist_ch0;
  logic [CH_W-1:0]   hist_ch1;
  logic [1:0]        fill;
  logic              s1_valid;
  logic [CH_W-1:0]   s1_ch;
  logic [CMD_W-1:0]  s1_sample;
  logic [CMD_W-1:0]  prev_mem [MAX_CH];
  logic [MAX_CH-1:0] prev_ok;
  logic [IDX_W-1:0]  idx;
  logic [CMD_W-1:0]  prev;
  logic [VAL_W-1:0]  value;

  assign accept = cmd_valid && cmd_ready;
  assign start  = running && !running_q;

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      running_q  <= 1'b0;
      cur_read   <= 1'b1;
      hist_read  <= 2'b11;
      fill       <= '0;
      s1_valid   <= 1'b0;
      word_valid <= 1'b0;
      prev_ok    <= '0;
    end else begin
      running_q <= running;
      if (accept) begin
        cur_read <= cmd_is_read;
      end
      // Response k pairs with command k-2
      if (rx_valid) begin
        hist_read <= {hist_read[0], cur_read};
      end
      if (start) begin
        fill <= '0;
      end else if (rx_valid && fill != 2'd2) begin
        fill <= fill + 2'd1;
      end
      s1_valid   <= rx_valid && (fill == 2'd2) && !hist_read[1];
      word_valid <= s1_valid;
      if (start) begin
        prev_ok <= '0;
      end else if (s1_valid) begin
        prev_ok[idx] <= 1'b1;
      end
    end
  end

  // Channel tags and stage 1 payload
  always_ff @(posedge bus_clk) begin
    if (accept) begin
      cur_ch <= cmd_channel;
    end
    if (rx_valid) begin
      hist_ch0  <= cur_ch;
      hist_ch1  <= hist_ch0;
      s1_ch     <= hist_ch1;
      s1_sample <= rx_word;
    end
  end

  // Stage 2 takes the first difference against the channel's last sample
  assign idx   = s1_ch[IDX_W-1:0];
  assign prev  = prev_ok[idx] ? prev_mem[idx] : '0;
  assign value = filter_en ? ({1'b0, s1_sample} - {1'b0, prev}) : {1'b0, s1_sample};

  always_ff @(posedge bus_clk) begin
    if (s1_valid) begin
      prev_mem[idx] <= s1_sample;
      word_data     <= {5'b0, s1_ch, value};
    end
  end

endmodule

`default_nettype wire

//--- src/spi_acq_pkg.sv
`default_nettype none

package spi_acq_pkg;

  // Word widths
  localparam int CMD_W      = 16;
  localparam int CH_W       = 10;
  localparam int REG_ADDR_W = 5;
  localparam int REG_DATA_W = 16;
  localparam int HOST_W     = 32;

  // Host register map with settings low and status high
  localparam logic [REG_ADDR_W-1:0] REG_RUN       = 5'd0;
  localparam logic [REG_ADDR_W-1:0] REG_NUM_CH    = 5'd1;
  localparam logic [REG_ADDR_W-1:0] REG_FILTER_EN = 5'd2;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS    = 5'd16;
  localparam logic [REG_ADDR_W-1:0] REG_FRAME_CNT = 5'd17;

  // Intan opcodes
  localparam logic [1:0] OP_CONVERT = 2'b00;
  localparam logic [1:0] OP_READ    = 2'b11;

  // Chip ID registers read at the tail of every frame
  localparam logic [5:0] CHIP_ID_REG0 = 6'd40;
  localparam logic [5:0] CHIP_ID_REG1 = 6'd41;

  // Idle clocks with CS high between transfers
  localparam int CS_GAP_CYCLES = 4;

  // One command word, seen as convert or as register access
  typedef union packed {
    struct packed {
      logic [1:0] opcode;
      logic [5:0] channel;
      logic [7:0] zero;
    } conv;
    struct packed {
      logic [1:0] opcode;
      logic [5:0] reg_addr;
      logic [7:0] data;
    } regv;
  } intan_cmd_u;

endpackage

`default_nettype wire

//--- src/spi_acq_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_acq_top #(
  parameter int MAX_CH     = 32,
  parameter int SCLK_DIV   = 2,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                              bus_clk,
  input  logic                              reset,
  input  logic                              reg_wren,
  input  logic                              reg_rden,
  input  logic [spi_acq_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [spi_acq_pkg::REG_DATA_W-1:0] reg_wdata,
  output logic [spi_acq_pkg::REG_DATA_W-1:0] reg_rdata,
  input  logic                              fifo_rden,
  output logic [spi_acq_pkg::HOST_W-1:0]     fifo_data,
  output logic                              fifo_empty,
  output logic                              sclk,
  output logic                              cs,
  output logic                              mosi,
  input  logic                              miso
);

  import spi_acq_pkg::*;

  logic              run;
  logic [6:0]        num_ch;
  logic              filter_en;
  logic              running;
  logic [15:0]       frame_count;
  logic              overflow_pulse;
  logic              cmd_valid;
  logic              cmd_ready;
  intan_cmd_u        cmd_word;
  logic              cmd_is_read;
  logic [CH_W-1:0]   cmd_channel;
  logic              rx_valid;
  logic [CMD_W-1:0]  rx_word;
  logic              word_valid;
  logic [HOST_W-1:0] word_data;

  acq_ctrl_regs #(.MAX_CH(MAX_CH)) u_regs (
    .bus_clk(bus_clk), .reset(reset),
    .reg_wren(reg_wren), .reg_rden(reg_rden), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .running(running), .frame_count(frame_count),
    .overflow_pulse(overflow_pulse), .reg_rdata(reg_rdata),
    .run(run), .num_ch(num_ch), .filter_en(filter_en)
  );

  intan_cmd_seq #(.MAX_CH(MAX_CH)) u_seq (
    .bus_clk(bus_clk), .reset(reset), .run(run), .num_ch(num_ch),
    .cmd_ready(cmd_ready), .cmd_valid(cmd_valid), .cmd_word(cmd_word),
    .cmd_is_read(cmd_is_read), .cmd_channel(cmd_channel),
    .running(running), .frame_count(frame_count)
  );

  spi_master_engine #(.SCLK_DIV(SCLK_DIV)) u_engine (
    .bus_clk(bus_clk), .reset(reset), .cmd_valid(cmd_valid),
    .cmd_word(cmd_word), .miso(miso), .cmd_ready(cmd_ready),
    .sclk(sclk), .cs(cs), .mosi(mosi),
    .rx_valid(rx_valid), .rx_word(rx_word)
  );

  // Tags are taken from the command handshake itself
  mua_packer #(.MAX_CH(MAX_CH)) u_packer (
    .bus_clk(bus_clk), .reset(reset), .running(running),
    .filter_en(filter_en), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .cmd_is_read(cmd_is_read), .cmd_channel(cmd_channel),
    .rx_valid(rx_valid), .rx_word(rx_word),
    .word_valid(word_valid), .word_data(word_data)
  );

  host_stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .bus_clk(bus_clk), .reset(reset), .word_valid(word_valid),
    .word_data(word_data), .fifo_rden(fifo_rden), .fifo_data(fifo_data),
    .fifo_empty(fifo_empty), .overflow_pulse(overflow_pulse)
  );

endmodule

`default_nettype wire

//--- src/spi_master_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_engine #(
  parameter int SCLK_DIV = 2
) (
  input  logic                         bus_clk,
  input  logic                         reset,
  input  logic                         cmd_valid,
  input  logic [spi_acq_pkg::CMD_W-1:0] cmd_word,
  input  logic                         miso,
  output logic                         cmd_ready,
  output logic                         sclk,
  output logic                         cs,
  output logic                         mosi,
  output logic                         rx_valid,
  output logic [spi_acq_pkg::CMD_W-1:0] rx_word
);

  import spi_acq_pkg::*;

  localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
  localparam int GAP_W = (CS_GAP_CYCLES > 1) ? $clog2(CS_GAP_CYCLES) : 1;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    GAP
  } state_t;

  state_t           state;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_cnt;
  logic [GAP_W-1:0] gap_cnt;
  logic [CMD_W-1:0] tx_shift;
  logic [CMD_W-1:0] rx_shift;
  logic             tick;
  logic             accept;

  // Half SCLK period done
  assign tick = (state == SHIFT) && (div_cnt == DIV_W'(SCLK_DIV - 1));

  // Ready in the last gap cycle so CS stays high exactly the gap length
  assign cmd_ready = (state == IDLE) ||
                     ((state == GAP) && (gap_cnt == GAP_W'(CS_GAP_CYCLES - 1)));
  assign accept    = cmd_valid && cmd_ready;

  assign mosi    = tx_shift[CMD_W-1];
  assign rx_word = rx_shift;

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      state    <= IDLE;
      cs       <= 1'b1;
      sclk     <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (accept) begin
        state   <= SHIFT;
        cs      <= 1'b0;
        div_cnt <= '0;
        bit_cnt <= '0;
      end else begin
        case (state)
          SHIFT: begin
            if (tick) begin
              div_cnt <= '0;
              sclk    <= ~sclk;
              // Falling edge closes a bit
              if (sclk) begin
                if (bit_cnt == 4'(CMD_W - 1)) begin
                  state    <= GAP;
                  cs       <= 1'b1;
                  rx_valid <= 1'b1;
                  gap_cnt  <= '0;
                end else begin
                  bit_cnt <= bit_cnt + 4'd1;
                end
              end
            end else begin
              div_cnt <= div_cnt + DIV_W'(1);
            end
          end
          GAP: begin
            if (gap_cnt == GAP_W'(CS_GAP_CYCLES - 1)) begin
              state <= IDLE;
            end else begin
              gap_cnt <= gap_cnt + GAP_W'(1);
            end
          end
          default: ;
        endcase
      end
    end
  end

  // MOSI moves on falling SCLK, MISO captured on rising SCLK
  always_ff @(posedge bus_clk) begin
    if (accept) begin
      tx_shift <= cmd_word;
    end else if (tick && sclk) begin
      tx_shift <= {tx_shift[CMD_W-2:0], 1'b0};
    end
    if (tick && !sclk) begin
      rx_shift <= {rx_shift[CMD_W-2:0], miso};
    end
  end

  a_cs_sclk: assert property (@(posedge bus_clk) disable iff (reset) cs |-> !sclk)
    else $error("SCLK toggled while CS was high");

endmodule

`default_nettype wire

//--- tb.f
src/spi_acq_pkg.sv
src/acq_ctrl_regs.sv
src/intan_cmd_seq.sv
src/spi_master_engine.sv
src/mua_packer.sv
src/host_stream_fifo.sv
src/spi_acq_top.sv
tests/spi_acq_tb.sv

//--- tests/spi_acq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_acq_tb;

  import spi_acq_pkg::*;

  localparam int MAX_CH       = 32;
  localparam int FIFO_DEPTH   = 16;
  localparam int WORD_TIMEOUT = 2000;
  localparam int POLL_TIMEOUT = 10000;
  localparam int IDLE_CYCLES  = 8;

  logic                  bus_clk;
  logic                  reset;
  logic                  reg_wren;
  logic                  reg_rden;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [REG_DATA_W-1:0] reg_wdata;
  logic [REG_DATA_W-1:0] reg_rdata;
  logic                  fifo_rden;
  logic [HOST_W-1:0]     fifo_data;
  logic                  fifo_empty;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  miso;

  integer seed;

  // Chip model state
  logic        cs_q;
  logic        sclk_q;
  logic [15:0] mosi_shift;
  logic [15:0] miso_shift;
  logic [15:0] resp_q[$];
  int          frame_idx;
  int          seq_n;
  int          seq_slot;

  // Expected host stream filled as the chip answers converts
  int          exp_ch_q[$];
  logic [15:0] exp_sample_q[$];
  logic [15:0] prev_sample[MAX_CH];
  logic        filter_on;

  spi_acq_top DUT (
    .bus_clk(bus_clk), .reset(reset),
    .reg_wren(reg_wren), .reg_rden(reg_rden), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .fifo_rden(fifo_rden), .fifo_data(fifo_data), .fifo_empty(fifo_empty),
    .sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso)
  );

  initial begin
    bus_clk = 1'b0;
    forever #50 bus_clk = ~bus_clk;
  end

  sclk_idle_check: assert property (@(posedge bus_clk) disable iff (reset) cs |-> !sclk)
    else begin
      $display("FAILED sclk_idle: expected sclk 0 while cs high, actual %b", sclk);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out: %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // Command expected at a given slot of a frame
  function automatic logic [15:0] expected_command(input int slot, input int n);
    intan_cmd_u w;
    w = '0;
    if (slot < n) begin
      w.conv.opcode  = OP_CONVERT;
      w.conv.channel = 6'(slot);
    end else begin
      w.regv.opcode   = OP_READ;
      w.regv.reg_addr = (slot == n) ? CHIP_ID_REG0 : CHIP_ID_REG1;
    end
    return w;
  endfunction

  // Intan chip model whose answers leave two transfers after their command
  always @(negedge bus_clk) begin : chip_model
    intan_cmd_u  cmd;
    logic [15:0] sample;
    if (reset) begin
      cs_q      = 1'b1;
      sclk_q    = 1'b0;
      miso      = 1'b0;
      frame_idx = 0;
      resp_q.delete();
      resp_q.push_back(16'h0000);
      resp_q.push_back(16'h0000);
    end else begin
      if (cs_q && !cs) begin
        miso_shift = resp_q.pop_front();
        miso       = miso_shift[15];
      end else if (!cs && sclk_q && !sclk) begin
        miso_shift = {miso_shift[14:0], 1'b0};
        miso       = miso_shift[15];
      end
      if (!cs && !sclk_q && sclk) begin
        mosi_shift = {mosi_shift[14:0], mosi};
      end
      if (!cs_q && cs) begin
        cmd = mosi_shift;
        check_value("mosi_command", expected_command(seq_slot, seq_n), cmd);
        if (cmd.conv.opcode == OP_CONVERT) begin
          sample = 16'(cmd.conv.channel * 256 + frame_idx % 256);
          resp_q.push_back(sample);
          exp_ch_q.push_back(cmd.conv.channel);
          exp_sample_q.push_back(sample);
        end else begin
          resp_q.push_back(16'h0000);
          if (cmd.regv.reg_addr == CHIP_ID_REG1) begin
            frame_idx++;
          end
        end
        seq_slot = (seq_slot == seq_n + 1) ? 0 : seq_slot + 1;
      end
      cs_q   = cs;
      sclk_q = sclk;
    end
  end

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr,
                           input logic [REG_DATA_W-1:0] data);
    @(negedge bus_clk);
    reg_wren  = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge bus_clk);
    reg_wren = 1'b0;
  endtask

  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr,
                          output logic [REG_DATA_W-1:0] data);
    @(negedge bus_clk);
    reg_rden = 1'b1;
    reg_addr = addr;
    @(negedge bus_clk);
    reg_rden = 1'b0;
    data     = reg_rdata;
  endtask

  task automatic pop_word(output logic [HOST_W-1:0] word);
    int waited;
    waited = 0;
    @(negedge bus_clk);
    while (fifo_empty) begin
      if (waited == WORD_TIMEOUT) begin
        timeout_fail("no host word arrived from the FIFO");
      end
      waited++;
      @(negedge bus_clk);
    end
    word      = fifo_data;
    fifo_rden = 1'b1;
    @(negedge bus_clk);
    fifo_rden = 1'b0;
  endtask

  task automatic check_host_word(input string name);
    logic [HOST_W-1:0] got;
    logic [16:0]       value;
    logic [15:0]       sample;
    int                ch;
    pop_word(got);
    assert (exp_ch_q.size() > 0) else begin
      $display("Host word %0h arrived with no convert left to match it", got);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
    ch     = exp_ch_q.pop_front();
    sample = exp_sample_q.pop_front();
    if (filter_on) begin
      value = {1'b0, sample} - {1'b0, prev_sample[ch]};
    end else begin
      value = {1'b0, sample};
    end
    prev_sample[ch] = sample;
    check_value(name, {5'b0, 10'(ch), value}, got);
  endtask

  // CS held high long enough that no transfer is left
  task automatic wait_idle();
    int waited;
    int quiet;
    waited = 0;
    quiet  = 0;
    while (quiet < IDLE_CYCLES) begin
      if (waited == WORD_TIMEOUT) begin
        timeout_fail("SPI bus did not go idle");
      end
      waited++;
      @(negedge bus_clk);
      quiet = cs ? quiet + 1 : 0;
    end
  endtask

  task automatic drain_fifo();
    int pops;
    pops = 0;
    @(negedge bus_clk);
    while (!fifo_empty) begin
      if (pops == 2 * FIFO_DEPTH) begin
        timeout_fail("host FIFO did not empty while draining");
      end
      pops++;
      fifo_rden = 1'b1;
      @(negedge bus_clk);
      fifo_rden = 1'b0;
      @(negedge bus_clk);
    end
  endtask

  task automatic start_run(input int n, input logic filt);
    reg_write(REG_FILTER_EN, 16'(filt));
    reg_write(REG_NUM_CH, 16'(n));
    exp_ch_q.delete();
    exp_sample_q.delete();
    for (int i = 0; i < MAX_CH; i++) begin
      prev_sample[i] = '0;
    end
    filter_on = filt;
    seq_n     = n;
    seq_slot  = 0;
    reg_write(REG_RUN, 16'd1);
  endtask

  // Clear run and wait until the last frame has left the SPI bus
  task automatic halt_run();
    logic [REG_DATA_W-1:0] status;
    int                    polls;
    polls = 0;
    reg_write(REG_RUN, 16'd0);
    reg_read(REG_STATUS, status);
    while (status[0]) begin
      if (polls == POLL_TIMEOUT) begin
        timeout_fail("running bit stayed set after run was cleared");
      end
      polls++;
      reg_read(REG_STATUS, status);
    end
    wait_idle();
  endtask

  task automatic stop_run();
    halt_run();
    drain_fifo();
  endtask

  initial begin
    logic [REG_DATA_W-1:0] rdata;
    logic [REG_DATA_W-1:0] val;
    logic [REG_DATA_W-1:0] clamped;
    int                    n;
    int                    polls;
    seed      = 52;
    reset     = 1'b1;
    reg_wren  = 1'b0;
    reg_rden  = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    fifo_rden = 1'b0;
    miso      = 1'b0;
    filter_on = 1'b0;
    seq_n     = 1;
    seq_slot  = 0;
    repeat (3) @(negedge bus_clk);
    reset = 1'b0;

    // Idle state out of reset
    check_value("reset_cs", 1, cs);
    check_value("reset_sclk", 0, sclk);
    check_value("reset_fifo_empty", 1, fifo_empty);
    reg_read(REG_STATUS, rdata);
    check_value("reset_status", 0, rdata);

    // Channel count clamps with mostly small values around the limits
    for (int i = 0; i < 8; i++) begin
      val = (i == 7) ? 16'($random(seed)) : 16'($random(seed)) & 16'h003f;
      if (val == 0) begin
        clamped = 16'd1;
      end else if (val > MAX_CH) begin
        clamped = 16'(MAX_CH);
      end else begin
        clamped = val;
      end
      reg_write(REG_NUM_CH, val);
      reg_read(REG_NUM_CH, rdata);
      check_value("num_ch_readback", clamped, rdata);
    end
    reg_write(REG_FILTER_EN, 16'd1);
    reg_read(REG_FILTER_EN, rdata);
    check_value("filter_en_readback", 1, rdata);
    reg_write(REG_FILTER_EN, 16'd0);
    reg_read(REG_FILTER_EN, rdata);
    check_value("filter_en_readback", 0, rdata);

    // Raw samples over two frames
    n = ($random(seed) & 7) + 1;
    start_run(n, 1'b0);
    for (int i = 0; i < 2 * n; i++) begin
      check_host_word("raw_data");
    end
    stop_run();

    // First difference over three frames
    n = ($random(seed) & 7) + 1;
    start_run(n, 1'b1);
    for (int i = 0; i < 3 * n; i++) begin
      check_host_word("filtered_data");
    end
    stop_run();

    // Host withholds reads until the FIFO overflows
    n = ($random(seed) & 7) + 1;
    start_run(n, 1'b0);
    polls = 0;
    reg_read(REG_STATUS, rdata);
    while (!rdata[1]) begin
      if (polls == POLL_TIMEOUT) begin
        timeout_fail("overflow bit never set with the FIFO left full");
      end
      polls++;
      reg_read(REG_STATUS, rdata);
    end
    check_value("overflow_running", 1, rdata[0]);

    // The last frame still drops words into the full FIFO after run clears
    halt_run();
    reg_read(REG_FRAME_CNT, rdata);
    check_value("frame_count", 16'(frame_idx), rdata);
    reg_read(REG_STATUS, rdata);
    check_value("stopped_status", 2, rdata);
    reg_write(REG_RUN, 16'd0);
    reg_read(REG_STATUS, rdata);
    check_value("overflow_clear", 0, rdata);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
